/* Makefile */
# Verilator build and run of the mailbox bridge testbench

SRCS := $(shell grep -v '^+' sim.f)

obj_dir/Vtb_top: sim.f $(SRCS)
	verilator --binary --timing --top-module tb_top -f sim.f -o Vtb_top

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* logic/axi_ctrl_top.sv */
// Mailbox bridge control block.
// Register-bus and stream queues feeding one dispatcher and the local
// register file.

`timescale 1ns/1ns

module axi_ctrl_top import ctrl_types_pkg::*; (
    input  logic  axi_aclk,
    input  logic  axi_aresetn,
    output logic  axi_interrupt,
    // register-bus slave side
    input  logic  bk_ls_wstart,
    input  addr_t bk_ls_waddr,
    input  data_t bk_ls_wdata,
    input  strb_t bk_ls_wstrb,
    input  logic  bk_ls_rstart,
    input  addr_t bk_ls_raddr,
    output data_t bk_ls_rdata,
    output logic  bk_ls_rdone,
    // stream slave side
    input  data_t bk_ss_data,
    input  user_t bk_ss_user,
    input  logic  bk_ss_valid,
    output logic  bk_ss_ready
);

    logic        ls_valid;
    req_kind_t   ls_kind;
    addr_t       ls_addr;
    data_t       ls_wdata;
    strb_t       ls_wstrb;
    logic        ls_pop;
    logic        ss_valid;
    addr_t       ss_addr;
    data_t       ss_wdata;
    strb_t       ss_wstrb;
    logic        ss_pop;
    logic        reg_we;
    reg_target_t reg_target;
    word_idx_t   reg_idx;
    data_t       reg_wdata;
    strb_t       reg_wstrb;
    logic        set_int_stat;
    data_t       reg_rdata;

    ls_req_queue u_ls_queue (.*);

    ss_beat_pair u_ss_pair (.*);

    req_dispatch u_dispatch (.*);

    mbox_regs u_regs (.*);

endmodule

/* logic/ctrl_map_pkg.sv */
// Address map of the local register file.
// Mailbox window, interrupt words and stream user codes.

package ctrl_map_pkg;

    import ctrl_types_pkg::*;

    // ----------------------------------------
    // mailbox window
    // ----------------------------------------
    localparam addr_t MB_LOW   = 15'h2000;
    localparam addr_t MB_HIGH  = 15'h201F;
    localparam int    MB_WORDS = 8;

    // ----------------------------------------
    // interrupt words
    // ----------------------------------------
    // bit 0 enable, other bits read zero
    localparam addr_t INT_EN_ADDR   = 15'h2100;
    // bit 0 status, write one to clear
    localparam addr_t INT_STAT_ADDR = 15'h2104;

    // read value for anything outside the map
    localparam data_t ALL_ONES_DATA = 32'hFFFF_FFFF;

    // stream user code of a two-beat remote write
    localparam user_t USER_REM_WR = 2'b01;

endpackage

/* logic/ctrl_types_pkg.sv */
// Data types for the mailbox bridge control block.
// Widths, vector typedefs and state enums shared by queues, dispatcher
// and register file.

package ctrl_types_pkg;

    // ----------------------------------------
    // vector types
    // ----------------------------------------
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [14:0] addr_t;
    typedef logic [27:0] rem_addr_t;
    typedef logic [1:0]  user_t;
    typedef logic [2:0]  word_idx_t;

    // ----------------------------------------
    // enums
    // ----------------------------------------
    typedef enum logic {req_write, req_read} req_kind_t;
    typedef enum logic {src_ls, src_ss} src_t;

    typedef enum logic [1:0] {st_wait, st_decide, st_move, st_trig_int} disp_state_t;

    typedef enum logic [2:0] {
        tgt_mbox, tgt_int_en, tgt_int_stat, tgt_unsupp, tgt_none
    } reg_target_t;

    // queue entry widths and depth
    // register-bus entry is kind + address + data + strobes
    localparam int LS_ENTRY_W = 52;
    // stream beat is data + user code
    localparam int SS_BEAT_W  = 34;
    localparam int REQ_DEPTH  = 8;

endpackage

/* logic/ls_req_queue.sv */
// Register-bus request queue.
// Packs write and read starts into entries and unpacks the queue head.

`timescale 1ns/1ns

module ls_req_queue import ctrl_types_pkg::*; (
    input  logic      axi_aclk,
    input  logic      axi_aresetn,
    input  logic      bk_ls_wstart,
    input  addr_t     bk_ls_waddr,
    input  data_t     bk_ls_wdata,
    input  strb_t     bk_ls_wstrb,
    input  logic      bk_ls_rstart,
    input  addr_t     bk_ls_raddr,
    output logic      ls_valid,
    output req_kind_t ls_kind,
    output addr_t     ls_addr,
    output data_t     ls_wdata,
    output strb_t     ls_wstrb,
    input  logic      ls_pop
);

    logic [LS_ENTRY_W-1:0] entry_in;
    logic [LS_ENTRY_W-1:0] head;
    logic                  kind_bit;

    // write {kind, addr, data, strb}, read {kind, addr, zero padding}
    assign entry_in = bk_ls_wstart ? {req_write, bk_ls_waddr, bk_ls_wdata, bk_ls_wstrb}
                                   : {req_read, bk_ls_raddr, data_t'(0), strb_t'(0)};

    req_fifo #(.WIDTH(LS_ENTRY_W), .DEPTH(REQ_DEPTH)) u_ls_fifo (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .wr_valid    (bk_ls_wstart || bk_ls_rstart),
        .wr_data     (entry_in),
        .wr_ready    (),
        .rd_valid    (ls_valid),
        .rd_data     (head),
        .rd_pop      (ls_pop)
    );

    assign {kind_bit, ls_addr, ls_wdata, ls_wstrb} = head;
    assign ls_kind = req_kind_t'(kind_bit);

endmodule

/* logic/mbox_regs.sv */
// Local register file of the bridge.
// Eight mailbox words, interrupt enable and status, read mux and the
// interrupt output.

`timescale 1ns/1ns

module mbox_regs import ctrl_types_pkg::*, ctrl_map_pkg::*; (
    input  logic        axi_aclk,
    input  logic        axi_aresetn,
    input  logic        reg_we,
    input  reg_target_t reg_target,
    input  word_idx_t   reg_idx,
    input  data_t       reg_wdata,
    input  strb_t       reg_wstrb,
    input  logic        set_int_stat,
    output data_t       reg_rdata,
    output logic        axi_interrupt
);

    data_t mbox [MB_WORDS];
    logic  int_en;
    logic  int_stat;

    // ----------------------------------------
    // register writes
    // ----------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            for (int w = 0; w < MB_WORDS; w++) begin
                mbox[w] <= '0;
            end
            int_en   <= 1'b0;
            int_stat <= 1'b0;
        end else begin
            if (reg_we && reg_target == tgt_mbox) begin
                for (int b = 0; b < $bits(strb_t); b++) begin
                    if (reg_wstrb[b]) begin
                        mbox[reg_idx][b*8 +: 8] <= reg_wdata[b*8 +: 8];
                    end
                end
            end
            // only bit 0 is writable
            if (reg_we && reg_target == tgt_int_en && reg_wstrb[0]) begin
                int_en <= reg_wdata[0];
            end
            // remote mailbox write sets status, local write one clears it
            if (set_int_stat) begin
                int_stat <= 1'b1;
            end else if (reg_we && reg_target == tgt_int_stat && reg_wstrb[0]
                         && reg_wdata[0]) begin
                int_stat <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // read mux
    // ----------------------------------------
    always_comb begin
        case (reg_target)
            tgt_mbox:     reg_rdata = mbox[reg_idx];
            tgt_int_en:   reg_rdata = {31'b0, int_en};
            tgt_int_stat: reg_rdata = {31'b0, int_stat};
            tgt_unsupp:   reg_rdata = ALL_ONES_DATA;
            default:      reg_rdata = '0;
        endcase
    end

    assign axi_interrupt = int_en && int_stat;

endmodule

/* logic/req_dispatch.sv */
// Request dispatcher.
// Round-robin pick between the two queues, address decode and the
// FSM that moves each request into the register file.

`timescale 1ns/1ns

module req_dispatch import ctrl_types_pkg::*, ctrl_map_pkg::*; (
    input  logic        axi_aclk,
    input  logic        axi_aresetn,
    input  logic        ls_valid,
    input  req_kind_t   ls_kind,
    input  addr_t       ls_addr,
    input  data_t       ls_wdata,
    input  strb_t       ls_wstrb,
    output logic        ls_pop,
    input  logic        ss_valid,
    input  addr_t       ss_addr,
    input  data_t       ss_wdata,
    input  strb_t       ss_wstrb,
    output logic        ss_pop,
    output logic        reg_we,
    output reg_target_t reg_target,
    output word_idx_t   reg_idx,
    output data_t       reg_wdata,
    output strb_t       reg_wstrb,
    output logic        set_int_stat,
    input  data_t       reg_rdata,
    output data_t       bk_ls_rdata,
    output logic        bk_ls_rdone
);

    disp_state_t state;
    disp_state_t next_state;
    src_t        cur_src;
    src_t        last_src;
    src_t        pick;
    req_kind_t   cur_kind;
    addr_t       sel_addr;
    reg_target_t dec_target;
    word_idx_t   dec_idx;
    reg_target_t tgt_q;
    word_idx_t   idx_q;
    logic        leave;
    logic        rd_fire;

    // ----------------------------------------
    // arbitration
    // ----------------------------------------
    always_comb begin
        if (ls_valid && ss_valid) begin
            pick = (last_src == src_ss) ? src_ls : src_ss;
        end else if (ls_valid) begin
            pick = src_ls;
        end else begin
            pick = src_ss;
        end
    end

    // stream pairs are always writes
    assign cur_kind = (cur_src == src_ls) ? ls_kind : req_write;
    assign sel_addr = (cur_src == src_ls) ? ls_addr : ss_addr;

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    always_comb begin
        addr_t mb_off;
        mb_off  = sel_addr - MB_LOW;
        dec_idx = '0;
        if (sel_addr >= MB_LOW && sel_addr <= MB_HIGH) begin
            dec_target = tgt_mbox;
            dec_idx    = mb_off[4:2];
        end else if (cur_src == src_ss) begin
            // remote writes only reach the mailbox
            dec_target = tgt_none;
        end else if (sel_addr[14:2] == INT_EN_ADDR[14:2]) begin
            dec_target = tgt_int_en;
        end else if (sel_addr[14:2] == INT_STAT_ADDR[14:2]) begin
            dec_target = tgt_int_stat;
        end else begin
            dec_target = tgt_unsupp;
        end
    end

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_comb begin
        next_state = st_wait;
        case (state)
            st_wait:     next_state = (ls_valid || ss_valid) ? st_decide : st_wait;
            st_decide:   next_state = st_move;
            st_move: begin
                if (cur_src == src_ss && tgt_q == tgt_mbox) begin
                    next_state = st_trig_int;
                end
            end
            st_trig_int: next_state = st_wait;
            default:     next_state = st_wait;
        endcase
    end

    // entry leaves its queue as the FSM goes back to wait
    assign leave   = (state != st_wait) && (next_state == st_wait);
    assign ls_pop  = leave && (cur_src == src_ls);
    assign ss_pop  = leave && (cur_src == src_ss);
    assign rd_fire = (state == st_move) && (cur_src == src_ls) && (ls_kind == req_read);

    assign reg_we       = (state == st_move) && (cur_kind == req_write);
    assign reg_target   = tgt_q;
    assign reg_idx      = idx_q;
    assign reg_wdata    = (cur_src == src_ls) ? ls_wdata : ss_wdata;
    assign reg_wstrb    = (cur_src == src_ls) ? ls_wstrb : ss_wstrb;
    assign set_int_stat = (state == st_trig_int);

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state       <= st_wait;
            cur_src     <= src_ls;
            last_src    <= src_ss;
            tgt_q       <= tgt_none;
            idx_q       <= '0;
            bk_ls_rdone <= 1'b0;
            bk_ls_rdata <= '0;
        end else begin
            state <= next_state;
            if (state == st_wait && next_state == st_decide) begin
                cur_src <= pick;
            end
            if (state == st_decide) begin
                tgt_q    <= dec_target;
                idx_q    <= dec_idx;
                last_src <= cur_src;
            end
            // read data only valid alongside the done pulse
            bk_ls_rdone <= rd_fire;
            bk_ls_rdata <= rd_fire ? reg_rdata : '0;
        end
    end

endmodule

/* logic/req_fifo.sv */
// Synchronous request FIFO.
// Circular buffer with occupancy count, oldest entry shown at the output.

`timescale 1ns/1ns

module req_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             axi_aclk,
    input  logic             axi_aresetn,
    input  logic             wr_valid,
    input  logic [WIDTH-1:0] wr_data,
    output logic             wr_ready,
    output logic             rd_valid,
    output logic [WIDTH-1:0] rd_data,
    input  logic             rd_pop
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // wrap at DEPTH so non power-of-two depths work
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_ready = (count != CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_pop && rd_valid;
    assign rd_data  = mem[rd_ptr];

    always_ff @(posedge axi_aclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* logic/ss_beat_pair.sv */
// Stream request queue with beat pairing.
// Queues stream beats, holds a remote-write header and presents the
// header plus data beat as one write request.

`timescale 1ns/1ns

module ss_beat_pair import ctrl_types_pkg::*, ctrl_map_pkg::*; (
    input  logic  axi_aclk,
    input  logic  axi_aresetn,
    input  data_t bk_ss_data,
    input  user_t bk_ss_user,
    input  logic  bk_ss_valid,
    output logic  bk_ss_ready,
    output logic  ss_valid,
    output addr_t ss_addr,
    output data_t ss_wdata,
    output strb_t ss_wstrb,
    input  logic  ss_pop
);

    logic [SS_BEAT_W-1:0] beat;
    logic                 beat_valid;
    logic                 beat_pop;
    data_t                beat_data;
    user_t                beat_user;
    logic                 have_hdr;
    data_t                hdr_q;
    rem_addr_t            hdr_addr;
    logic                 addr_ok;

    req_fifo #(.WIDTH(SS_BEAT_W), .DEPTH(REQ_DEPTH)) u_beat_fifo (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .wr_valid    (bk_ss_valid),
        .wr_data     ({bk_ss_data, bk_ss_user}),
        .wr_ready    (bk_ss_ready),
        .rd_valid    (beat_valid),
        .rd_data     (beat),
        .rd_pop      (beat_pop)
    );

    assign {beat_data, beat_user} = beat;

    // header beat is {strb[3:0], addr[27:0]}
    assign hdr_addr = hdr_q[27:0];
    assign ss_wstrb = hdr_q[31:28];
    assign ss_addr  = addr_t'(hdr_addr);
    assign ss_wdata = beat_data;

    // address must survive truncation to the register-bus width
    assign addr_ok  = (rem_addr_t'(ss_addr) == hdr_addr);
    assign ss_valid = have_hdr && beat_valid && addr_ok;

    always_comb begin
        if (!beat_valid) begin
            beat_pop = 1'b0;
        end else if (!have_hdr) begin
            // header taken, or a beat of another code dropped
            beat_pop = 1'b1;
        end else begin
            beat_pop = !addr_ok || ss_pop;
        end
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            have_hdr <= 1'b0;
        end else if (!have_hdr) begin
            have_hdr <= beat_valid && (beat_user == USER_REM_WR);
        end else if (beat_pop) begin
            have_hdr <= 1'b0;
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (beat_valid && !have_hdr) begin
            hdr_q <= beat_data;
        end
    end

endmodule

/* sim.f */
logic/ctrl_types_pkg.sv
logic/ctrl_map_pkg.sv
logic/req_fifo.sv
logic/ls_req_queue.sv
logic/ss_beat_pair.sv
logic/req_dispatch.sv
logic/mbox_regs.sv
logic/axi_ctrl_top.sv
sim/tb_top.sv

/* sim/tb_top.sv */
// Testbench for the mailbox bridge control block.
// Register-bus and stream stimulus, a model of the register map and a
// checker for every read response.

`timescale 1ns/1ns

module tb_top
    import ctrl_types_pkg::*, ctrl_map_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int MIX_OPS      = 60;
    localparam int BURST_PAIRS  = 24;

    logic  axi_aclk;
    logic  axi_aresetn;
    logic  axi_interrupt;
    logic  bk_ls_wstart;
    addr_t bk_ls_waddr;
    data_t bk_ls_wdata;
    strb_t bk_ls_wstrb;
    logic  bk_ls_rstart;
    addr_t bk_ls_raddr;
    data_t bk_ls_rdata;
    logic  bk_ls_rdone;
    data_t bk_ss_data;
    user_t bk_ss_user;
    logic  bk_ss_valid;
    logic  bk_ss_ready;

    // model of the register map
    data_t     mbox_m [MB_WORDS];
    logic      en_m;
    logic      stat_m;
    // outstanding reads, oldest first
    data_t     exp_q [$];
    string     name_q [$];
    bit        chk_q [$];
    data_t     cmp_exp;
    string     cmp_name;
    bit        cmp_chk;
    data_t     last_rdata;
    int        rd_count = 0;
    int        mism_count = 0;
    int        other_fails = 0;
    int        ops_issued = 0;
    int        cycles = 0;
    int        wr_run = 0;
    integer    seed = 32'hfd1c8511;
    bit        ready_dropped = 1'b0;
    data_t     r;
    word_idx_t burst_w [BURST_PAIRS];
    data_t     burst_d [BURST_PAIRS];
    strb_t     burst_s [BURST_PAIRS];

    axi_ctrl_top DUT (.*);

    initial axi_aclk = 1'b0;
    always #2 axi_aclk = ~axi_aclk;

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w,
                                          input strb_t strb);
        data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic addr_t mb_addr(input word_idx_t w);
        return MB_LOW + addr_t'({w, 2'b00});
    endfunction

    function automatic data_t ref_read(input addr_t addr);
        if (addr >= MB_LOW && addr <= MB_HIGH) begin
            return mbox_m[word_idx_t'((addr - MB_LOW) >> 2)];
        end else if (addr == INT_EN_ADDR) begin
            return data_t'(en_m);
        end else if (addr == INT_STAT_ADDR) begin
            return data_t'(stat_m);
        end
        return 32'hFFFF_FFFF;
    endfunction

    function automatic void model_ls_write(input addr_t addr, input data_t data,
                                           input strb_t strb);
        if (addr >= MB_LOW && addr <= MB_HIGH) begin
            mbox_m[word_idx_t'((addr - MB_LOW) >> 2)] =
                merge_bytes(mbox_m[word_idx_t'((addr - MB_LOW) >> 2)], data, strb);
        end else if (addr == INT_EN_ADDR && strb[0]) begin
            en_m = data[0];
        end else if (addr == INT_STAT_ADDR && strb[0] && data[0]) begin
            stat_m = 1'b0;
        end
    endfunction

    // ----------------------------------------
    // checks and end of run
    // ----------------------------------------
    task automatic check_value(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
            mism_count++;
        end
    endtask

    task automatic end_run();
        $display("errors: %0d mismatches, %0d other failures", mism_count, other_fails);
        if (mism_count == 0 && other_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // ----------------------------------------
    // register-bus and stream drivers
    // ----------------------------------------
    task automatic do_write(input addr_t addr, input data_t data, input strb_t strb);
        model_ls_write(addr, data, strb);
        ops_issued++;
        @(negedge axi_aclk);
        bk_ls_wstart = 1'b1;
        bk_ls_waddr  = addr;
        bk_ls_wdata  = data;
        bk_ls_wstrb  = strb;
        @(negedge axi_aclk);
        bk_ls_wstart = 1'b0;
    endtask

    // waits for the matching done pulse
    task automatic do_read(input string name, input addr_t addr, input bit chk);
        int seen;
        exp_q.push_back(ref_read(addr));
        name_q.push_back(name);
        chk_q.push_back(chk);
        seen = rd_count;
        ops_issued++;
        @(negedge axi_aclk);
        bk_ls_rstart = 1'b1;
        bk_ls_raddr  = addr;
        @(negedge axi_aclk);
        bk_ls_rstart = 1'b0;
        wait (rd_count != seen);
    endtask

    task automatic send_beat(input data_t data, input user_t user);
        @(negedge axi_aclk);
        bk_ss_valid = 1'b1;
        bk_ss_data  = data;
        bk_ss_user  = user;
        // ready only moves on the rising edge
        while (!bk_ss_ready) begin
            @(negedge axi_aclk);
        end
        @(posedge axi_aclk);
    endtask

    task automatic send_pair(input word_idx_t w, input data_t data, input strb_t strb,
                             input user_t user);
        if (user == USER_REM_WR) begin
            mbox_m[w] = merge_bytes(mbox_m[w], data, strb);
            stat_m    = 1'b1;
        end
        ops_issued++;
        send_beat({strb, 13'b0, mb_addr(w)}, user);
        send_beat(data, user);
    endtask

    task automatic stop_stream();
        @(negedge axi_aclk);
        bk_ss_valid = 1'b0;
    endtask

    // stream writes have no completion, so read until the word settles
    task automatic poll_word(input word_idx_t w);
        for (int k = 0; k < 16; k++) begin
            do_read("stream_land", mb_addr(w), 1'b0);
            if (last_rdata == mbox_m[w]) begin
                break;
            end
        end
        check_value("stream_land", mbox_m[w], last_rdata);
    endtask

    // ----------------------------------------
    // read checker, monitor and timeout
    // ----------------------------------------
    always @(negedge axi_aclk) begin
        if (axi_aresetn && bk_ls_rdone) begin
            if (exp_q.size() == 0) begin
                $display("read done pulse seen with no read outstanding");
                other_fails++;
            end else begin
                cmp_exp  = exp_q.pop_front();
                cmp_name = name_q.pop_front();
                cmp_chk  = chk_q.pop_front();
                if (cmp_chk) begin
                    check_value(cmp_name, cmp_exp, bk_ls_rdata);
                end
            end
            last_rdata = bk_ls_rdata;
            rd_count++;
        end
        if (axi_aresetn && !bk_ss_ready) begin
            ready_dropped = 1'b1;
        end
    end

    // budget grows by 40 cycles with every issued operation
    always @(posedge axi_aclk) begin
        cycles++;
        if (cycles > 40 * (ops_issued + 1) + RESET_CYCLES) begin
            $display("timeout after %0d cycles waiting for the DUT", cycles);
            other_fails++;
            end_run();
        end
    end

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        axi_aresetn  = 1'b0;
        bk_ls_wstart = 1'b0;
        bk_ls_waddr  = '0;
        bk_ls_wdata  = '0;
        bk_ls_wstrb  = '0;
        bk_ls_rstart = 1'b0;
        bk_ls_raddr  = '0;
        bk_ss_data   = '0;
        bk_ss_user   = '0;
        bk_ss_valid  = 1'b0;
        for (int w = 0; w < MB_WORDS; w++) begin
            mbox_m[w] = '0;
        end
        en_m   = 1'b0;
        stat_m = 1'b0;
        repeat (RESET_CYCLES) @(negedge axi_aclk);
        axi_aresetn = 1'b1;

        // after reset
        @(negedge axi_aclk);
        check_value("reset_rdone", 32'd0, data_t'(bk_ls_rdone));
        check_value("reset_rdata", 32'd0, bk_ls_rdata);
        check_value("reset_irq", 32'd0, data_t'(axi_interrupt));
        check_value("reset_ready", 32'd1, data_t'(bk_ss_ready));
        for (int w = 0; w < MB_WORDS; w++) begin
            do_read("reset_mbox", mb_addr(word_idx_t'(w)), 1'b1);
        end

        // strobed mailbox writes and unmapped addresses
        do_write(mb_addr(0), 32'h1122_3344, 4'b1111);
        do_write(mb_addr(0), 32'hAABB_CCDD, 4'b0101);
        do_write(mb_addr(1), 32'h99AA_BBCC, 4'b1000);
        do_write(mb_addr(3), 32'h5566_7788, 4'b0011);
        for (int w = 0; w < 4; w++) begin
            do_read("strobe_mbox", mb_addr(word_idx_t'(w)), 1'b1);
        end
        do_write(15'h2040, 32'hFFFF_FFFF, 4'b1111);
        do_write(15'h0100, 32'h1234_5678, 4'b1111);
        do_read("unmapped_2020", 15'h2020, 1'b1);
        do_read("unmapped_2040", 15'h2040, 1'b1);
        do_read("unmapped_20fc", 15'h20FC, 1'b1);
        do_read("unmapped_user", 15'h0100, 1'b1);
        do_read("unmapped_2108", 15'h2108, 1'b1);
        do_read("unmapped_keep", mb_addr(0), 1'b1);

        // interrupt enable and status
        do_write(INT_EN_ADDR, 32'hFFFF_FFFF, 4'b1111);
        do_read("int_en_set", INT_EN_ADDR, 1'b1);
        do_write(INT_STAT_ADDR, 32'hFFFF_FFFF, 4'b1111);
        do_read("int_stat_clear", INT_STAT_ADDR, 1'b1);
        do_write(INT_EN_ADDR, 32'h0, 4'b1111);
        do_read("int_en_off", INT_EN_ADDR, 1'b1);

        // remote mailbox writes and the interrupt
        send_pair(3'd5, 32'hCAFE_0005, 4'b1111, USER_REM_WR);
        stop_stream();
        poll_word(3'd5);
        // status already set while the enable bit is still clear
        check_value("remote_irq_masked", data_t'(en_m & stat_m), data_t'(axi_interrupt));
        do_read("remote_stat", INT_STAT_ADDR, 1'b1);
        do_write(INT_EN_ADDR, 32'h1, 4'b0001);
        wait (axi_interrupt == 1'b1);
        do_write(INT_STAT_ADDR, 32'h1, 4'b0001);
        wait (axi_interrupt == 1'b0);
        do_read("remote_stat_clr", INT_STAT_ADDR, 1'b1);
        // the code 01 pair behind the dropped code 10 pair marks completion
        send_pair(3'd6, 32'hDEAD_0006, 4'b1111, 2'b10);
        send_pair(3'd7, 32'h7777_0007, 4'b0110, USER_REM_WR);
        stop_stream();
        wait (axi_interrupt == 1'b1);
        do_read("code10_mbox6", mb_addr(6), 1'b1);
        do_read("remote_mbox7", mb_addr(7), 1'b1);
        do_write(INT_STAT_ADDR, 32'h1, 4'b0001);
        wait (axi_interrupt == 1'b0);

        // mixed traffic against a stream burst to words 4 to 7
        for (int p = 0; p < BURST_PAIRS; p++) begin
            r          = $random(seed);
            burst_w[p] = word_idx_t'({1'b1, r[1:0]});
            burst_s[p] = r[7:4] | 4'b0001;
            burst_d[p] = $random(seed);
        end
        fork
            begin
                for (int n = 0; n < MIX_OPS; n++) begin
                    r = $random(seed);
                    // a read after three writes keeps the queue shallow
                    if (r[2] || wr_run == 3) begin
                        do_read("mixed_read", mb_addr(word_idx_t'(r[1:0])), 1'b1);
                        wr_run = 0;
                    end else begin
                        do_write(mb_addr(word_idx_t'(r[1:0])), $random(seed), r[7:4]);
                        wr_run++;
                    end
                end
            end
            begin
                for (int p = 0; p < BURST_PAIRS; p++) begin
                    send_pair(burst_w[p], burst_d[p], burst_s[p], USER_REM_WR);
                end
                stop_stream();
            end
        join
        for (int w = 4; w < MB_WORDS; w++) begin
            poll_word(word_idx_t'(w));
        end
        if (!ready_dropped) begin
            $display("stream ready never dropped during the burst");
            other_fails++;
        end
        end_run();
    end

endmodule
